// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= rename_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TB PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
verilog/rename_pkg.sv
verilog/inst_decoder.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
tests/rename_checker.sv
tests/rename_core_tb.sv

// ==== tests/rename_checker.sv ====
// rename checker: reference model of renaming and retirement, compare and report
module rename_checker
  import rename_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  int                    test_id,
  input  logic                  exp_check,
  input  logic                  exp_writes,
  input  logic [phys_idx_w-1:0] exp_t_new,
  input  logic                  exp_t1_ready,
  input  logic                  inst_valid,
  input  logic [31:0]           inst_word,
  input  logic                  complete_valid,
  input  logic [rob_idx_w-1:0]  complete_rob_idx,
  input  logic                  dispatch_ready,
  input  logic [rob_idx_w-1:0]  dispatch_rob_idx,
  input  logic                  dispatch_writes,
  input  logic [phys_idx_w-1:0] dispatch_t_new,
  input  logic [phys_idx_w-1:0] dispatch_t_old,
  input  logic [phys_idx_w-1:0] dispatch_t1,
  input  logic                  dispatch_t1_ready,
  input  logic [phys_idx_w-1:0] dispatch_t2,
  input  logic                  dispatch_t2_ready,
  input  logic                  retire_valid,
  input  logic [arch_idx_w-1:0] retire_arch_reg,
  input  logic [phys_idx_w-1:0] retire_t_new,
  input  logic [phys_idx_w-1:0] retire_t_old,
  output int                    check_count,
  output int                    error_count
);

  timeunit 1ns;
  timeprecision 100ps;

  // map table and free list model
  int map_tag [32];
  bit map_rdy [32];
  int fl [$];
  // ROB model
  bit r_valid [8];
  bit r_done  [8];
  bit r_wr    [8];
  int r_arch  [8];
  int r_new   [8];
  int r_old   [8];
  int rh, rt, rc;
  // retirement expected after the coming edge
  bit ret_pend, ret_wr;
  int ret_arch, ret_new, ret_old;
  // per-test bookkeeping
  int cur_id;
  int test_err_base;

  task automatic compare(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("Fail %s: got 0x%0h, expected 0x%0h (test %0d)", name, got, exp, cur_id);
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    cur_id = 0;
    test_err_base = 0;
  end

  ////////////////////////////////////////////////////////////
  // per-cycle model step, inputs and outputs settled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    automatic int  opc = inst_word[31:26];
    automatic int  ra = inst_word[25:21];
    automatic int  rb = inst_word[20:16];
    automatic int  d = 31, s1 = 31, s2 = 31;
    automatic bit  take, wr, cdb_v, push_now, ret_now;
    automatic int  cdb_t, t1, t2, push_tag, ci;
    automatic bit  rdy1, rdy2;
    if (test_id != cur_id) begin
      if (cur_id != 0) begin
        $display("test %0d done, %0d errors", cur_id, error_count - test_err_base);
      end
      cur_id = test_id;
      test_err_base = error_count;
    end
    if (reset) begin
      for (int r = 0; r < 32; r++) begin
        map_tag[r] = r;
        map_rdy[r] = 1;
      end
      fl.delete();
      for (int t = 32; t < 64; t++) begin
        fl.push_back(t);
      end
      for (int e = 0; e < 8; e++) begin
        r_valid[e] = 0;
        r_done[e] = 0;
      end
      rh = 0;
      rt = 0;
      rc = 0;
      ret_pend = 0;
    end else begin
      // retirement registered at the last edge
      compare("retire_valid", retire_valid, ret_pend);
      if (ret_pend && retire_valid) begin
        compare("retire_arch_reg", retire_arch_reg, ret_arch);
        if (ret_wr) begin
          compare("retire_t_new", retire_t_new, ret_new);
          compare("retire_t_old", retire_t_old, ret_old);
        end
      end
      push_now = ret_pend && ret_wr;
      push_tag = ret_old;
      compare("dispatch_ready", dispatch_ready, rc < 8);
      ci = complete_rob_idx;
      cdb_v = complete_valid && r_valid[ci] && r_wr[ci];
      cdb_t = r_new[ci];
      // decode by the format rules
      if (opc >= 'h10 && opc <= 'h13) begin
        d = inst_word[4:0];
        s1 = ra;
        if (!inst_word[12]) s2 = rb;
      end else if (opc == 'h29) begin
        d = ra;
        s1 = rb;
      end else if (opc == 'h2D) begin
        s1 = rb;
        s2 = ra;
      end
      wr = (d != 31);
      take = inst_valid && rc < 8;
      if (take) begin
        t1 = (s1 == 31) ? 31 : map_tag[s1];
        t2 = (s2 == 31) ? 31 : map_tag[s2];
        rdy1 = (s1 == 31) || map_rdy[s1] || (cdb_v && map_tag[s1] == cdb_t);
        rdy2 = (s2 == 31) || map_rdy[s2] || (cdb_v && map_tag[s2] == cdb_t);
        compare("dispatch_rob_idx", dispatch_rob_idx, rt);
        compare("dispatch_writes", dispatch_writes, wr);
        compare("dispatch_t1", dispatch_t1, t1);
        compare("dispatch_t1_ready", dispatch_t1_ready, rdy1);
        compare("dispatch_t2", dispatch_t2, t2);
        compare("dispatch_t2_ready", dispatch_t2_ready, rdy2);
        if (wr) begin
          compare("dispatch_t_new", dispatch_t_new, fl[0]);
          compare("dispatch_t_old", dispatch_t_old, map_tag[d]);
        end
        // hand-computed table values
        if (exp_check) begin
          compare("dispatch_writes (table)", dispatch_writes, exp_writes);
          compare("dispatch_t1_ready (table)", dispatch_t1_ready, exp_t1_ready);
          if (exp_writes) compare("dispatch_t_new (table)", dispatch_t_new, exp_t_new);
        end
      end
      // head retires on its completion mark from before this edge
      ret_now = r_valid[rh] && r_done[rh];
      ret_pend = ret_now;
      ret_wr = r_wr[rh];
      ret_arch = r_arch[rh];
      ret_new = r_new[rh];
      ret_old = r_old[rh];
      if (complete_valid && r_valid[ci]) r_done[ci] = 1;
      if (take) begin
        r_valid[rt] = 1;
        r_done[rt] = 0;
        r_wr[rt] = wr;
        r_arch[rt] = d;
        r_new[rt] = wr ? fl[0] : 0;
        r_old[rt] = map_tag[d];
        rt = (rt + 1) % 8;
      end
      if (ret_now) begin
        r_valid[rh] = 0;
        rh = (rh + 1) % 8;
      end
      rc = rc + (take ? 1 : 0) - (ret_now ? 1 : 0);
      // wakeup then rename, the new mapping starts not ready
      if (cdb_v) begin
        for (int r = 0; r < 32; r++) begin
          if (map_tag[r] == cdb_t) map_rdy[r] = 1;
        end
      end
      if (take && wr) begin
        map_tag[d] = fl.pop_front();
        map_rdy[d] = 0;
      end
      if (push_now) fl.push_back(push_tag);
    end
  end

endmodule

// ==== tests/rename_core_tb.sv ====
// rename core testbench with clock, reset, stimulus table and driving loop
module rename_core_tb
  import rename_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_rows   = 96;
  localparam int hold_limit = 20;
  localparam int drain_limit = 100;

  logic                  clock;
  logic                  reset;
  logic                  inst_valid;
  inst_word_t            inst_word;
  logic                  complete_valid;
  logic [rob_idx_w-1:0]  complete_rob_idx;
  logic                  dispatch_ready;
  logic [rob_idx_w-1:0]  dispatch_rob_idx;
  logic                  dispatch_writes;
  logic [phys_idx_w-1:0] dispatch_t_new;
  logic [phys_idx_w-1:0] dispatch_t_old;
  logic [phys_idx_w-1:0] dispatch_t1;
  logic                  dispatch_t1_ready;
  logic [phys_idx_w-1:0] dispatch_t2;
  logic                  dispatch_t2_ready;
  logic                  retire_valid;
  logic [arch_idx_w-1:0] retire_arch_reg;
  logic [phys_idx_w-1:0] retire_t_new;
  logic [phys_idx_w-1:0] retire_t_old;

  // row currently applied as seen by the checker
  int   test_id;
  logic exp_check;
  logic exp_writes;
  logic [phys_idx_w-1:0] exp_t_new;
  logic exp_t1_ready;
  int   check_count;
  int   error_count;

  // stimulus table with one row per cycle
  logic [31:0]           t_word   [max_rows];
  logic                  t_valid  [max_rows];
  logic                  t_cvalid [max_rows];
  logic [rob_idx_w-1:0]  t_cidx   [max_rows];
  int                    t_test   [max_rows];
  logic                  t_chk    [max_rows];
  logic                  t_wr     [max_rows];
  logic [phys_idx_w-1:0] t_tnew   [max_rows];
  logic                  t_rdy1   [max_rows];
  int                    n_rows;

  int accepted;
  int retired;
  int timeouts;

  rename_core u_rename_core (.*);

  rename_checker u_rename_checker (.*);

  always #20 clock = ~clock;

  // retirement counter for the final drain
  always @(posedge clock) begin
    if (!reset && retire_valid) begin
      retired <= retired + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // table construction
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] operate_word(input int opc, input int ra, input int rb,
                                               input int lit, input int rc);
    return {6'(opc), 5'(ra), 5'(rb), 3'b000, 1'(lit), 7'h00, 5'(rc)};
  endfunction

  function automatic logic [31:0] memory_word(input int opc, input int ra, input int rb);
    return {6'(opc), 5'(ra), 5'(rb), 16'h0010};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic valid, input logic cvalid,
                         input int cidx, input int test, input logic chk,
                         input logic wr, input int tnew, input logic rdy1);
    t_word[n_rows]   = word;
    t_valid[n_rows]  = valid;
    t_cvalid[n_rows] = cvalid;
    t_cidx[n_rows]   = rob_idx_w'(cidx);
    t_test[n_rows]   = test;
    t_chk[n_rows]    = chk;
    t_wr[n_rows]     = wr;
    t_tnew[n_rows]   = phys_idx_w'(tnew);
    t_rdy1[n_rows]   = rdy1;
    n_rows++;
  endtask

  task automatic build_table();
    int order [8] = '{4, 3, 2, 7, 6, 5, 1, 0};
    n_rows = 0;
    // first writer r1 <- r2 op r3
    add_row(operate_word(op_inta, 2, 3, 0, 1), 1, 0, 0, 1, 1, 1, 'h20, 1);
    // consumers before, during and after the completion cycle
    add_row(operate_word(op_inta, 1, 2, 0, 4), 1, 0, 0, 2, 1, 1, 'h21, 0);
    add_row(operate_word(op_intl, 1, 1, 0, 5), 1, 1, 0, 2, 1, 1, 'h22, 1);
    add_row(operate_word(op_ints, 1, 5, 0, 6), 1, 0, 0, 2, 1, 1, 'h23, 1);
    // load and store through r7 plus an r31 target and a literal
    add_row(memory_word(op_ldq, 7, 4), 1, 0, 0, 3, 1, 1, 'h24, 0);
    add_row(memory_word(op_stq, 7, 2), 1, 0, 0, 3, 1, 0, 0, 1);
    add_row(operate_word(op_intm, 1, 2, 0, 31), 1, 0, 0, 3, 1, 0, 0, 1);
    add_row(operate_word(op_inta, 2, 21, 1, 8), 1, 0, 0, 3, 1, 1, 'h25, 1);
    // fills the ROB so the next one waits until entry 1 retires
    add_row(operate_word(op_inta, 2, 3, 0, 9), 1, 0, 0, 4, 1, 1, 'h26, 1);
    add_row(operate_word(op_intl, 9, 9, 0, 10), 1, 1, 1, 4, 1, 1, 'h27, 0);
    // out-of-order completions with dispatch idle
    foreach (order[k]) begin
      add_row('0, 0, 1, order[k], 5, 0, 0, 0, 0);
    end
    // steady stream where each is completed two rows later and tags wrap
    for (int j = 0; j < 40; j++) begin
      add_row(operate_word(op_inta, 1 + (j + 7) % 30, 1 + (j + 13) % 30, 0, 1 + j % 30),
              1, j >= 2, j % 8, 5, 0, 0, 0, 0);
    end
    add_row('0, 0, 1, (2 + 38) % 8, 5, 0, 0, 0, 0);
    add_row('0, 0, 1, (2 + 39) % 8, 5, 0, 0, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // driving loop
  ////////////////////////////////////////////////////////////

  task automatic drive_row(input int i);
    inst_valid       = t_valid[i];
    inst_word        = t_word[i];
    complete_valid   = t_cvalid[i];
    complete_rob_idx = t_cidx[i];
    test_id          = t_test[i];
    exp_check        = t_chk[i];
    exp_writes       = t_wr[i];
    exp_t_new        = t_tnew[i];
    exp_t1_ready     = t_rdy1[i];
  endtask

  initial begin
    logic ready_now;
    logic taken;
    int   held;
    int   waited;
    clock = 1'b0;
    reset = 1'b1;
    accepted = 0;
    retired  = 0;
    timeouts = 0;
    test_id  = 0;
    inst_valid       = 1'b0;
    inst_word        = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    exp_check        = 1'b0;
    exp_writes       = 1'b0;
    exp_t_new        = '0;
    exp_t1_ready     = 1'b0;
    build_table();
    repeat (5) @(posedge clock);
    #2 reset = 1'b0;
    for (int i = 0; i < n_rows && timeouts == 0; i++) begin
      drive_row(i);
      held  = 0;
      taken = 1'b0;
      while (!taken && timeouts == 0) begin
        ready_now = dispatch_ready;
        @(posedge clock);
        #2;
        if (!t_valid[i] || ready_now) begin
          taken = 1'b1;
          if (t_valid[i]) begin
            accepted++;
          end
        end else begin
          // the completion in a held row counts once
          complete_valid = 1'b0;
          held++;
          if (held >= hold_limit) begin
            $display("timeout: row %0d never accepted, dispatch_ready stayed low", i);
            timeouts++;
          end
        end
      end
    end
    inst_valid     = 1'b0;
    complete_valid = 1'b0;
    exp_check      = 1'b0;
    // drain outstanding retirements
    waited = 0;
    while (retired < accepted && timeouts == 0) begin
      @(posedge clock);
      #2;
      waited++;
      if (waited >= drain_limit) begin
        $display("timeout: %0d of %0d instructions retired", retired, accepted);
        timeouts++;
      end
    end
    test_id = 0;
    @(negedge clock);
    @(posedge clock);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/free_list.sv ====
// free list: circular queue of free physical tags
module free_list
  import rename_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,
  input  logic                  push,
  input  logic [phys_idx_w-1:0] push_tag,
  output logic [phys_idx_w-1:0] head_tag
);

  logic [phys_idx_w-1:0] slots [free_regs];
  logic [fl_idx_w-1:0]   head;
  logic [fl_idx_w-1:0]   tail;
  // one bit wider so 32 fits
  logic [fl_idx_w:0]     count;

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags 32..63 in ascending order
      for (int i = 0; i < free_regs; i++) begin
        slots[i] <= phys_idx_w'(arch_regs + i);
      end
      head  <= '0;
      // full queue, so tail wraps onto head
      tail  <= '0;
      count <= (fl_idx_w + 1)'(free_regs);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      // freed tags join at the tail
      if (push) begin
        slots[tail] <= push_tag;
        tail        <= tail + 1'b1;
      end
      case ({pop, push})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  // next tag handed out at dispatch
  assign head_tag = slots[head];

  ////////////////////////////////////////////////////////////
  // occupancy checks
  ////////////////////////////////////////////////////////////

  // 8 ROB entries against 32 tags, dispatch never finds it empty
  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> (count != '0)
  );

  // a returned tag always has a slot waiting
  a_no_push_full: assert property (
    @(posedge clock) disable iff (reset) push |-> (count < free_regs)
  );

endmodule

// ==== verilog/inst_decoder.sv ====
// instruction decoder: destination, two sources, use flags and write flag
module inst_decoder
  import rename_pkg::*;
(
  input  inst_word_t            inst_word,
  output logic [arch_idx_w-1:0] dest,
  output logic [arch_idx_w-1:0] src1,
  output logic [arch_idx_w-1:0] src2,
  output logic                  src1_used,
  output logic                  src2_used,
  output logic                  writes
);

  logic [opcode_w-1:0] opcode;
  logic                is_operate;
  logic                is_load;
  logic                is_store;

  // opcode field is common to both views
  assign opcode = inst_word.operate.opcode;

  assign is_operate = (opcode == op_inta) || (opcode == op_intl) ||
                      (opcode == op_ints) || (opcode == op_intm);
  assign is_load    = (opcode == op_ldq);
  assign is_store   = (opcode == op_stq);

  // anything unused falls back to r31
  always_comb begin
    dest = zero_reg;
    src1 = zero_reg;
    src2 = zero_reg;
    if (is_operate) begin
      dest = inst_word.operate.rc;
      src1 = inst_word.operate.ra;
      // literal takes the place of rb
      if (!inst_word.operate.lit) begin
        src2 = inst_word.operate.rb;
      end
    end else if (is_load) begin
      dest = inst_word.memory.ra;
      src1 = inst_word.memory.rb;
    end else if (is_store) begin
      // base in rb, store data in ra
      src1 = inst_word.memory.rb;
      src2 = inst_word.memory.ra;
    end
  end

  // r31 as target or operand means nothing to rename or wait on
  assign writes    = (dest != zero_reg);
  assign src1_used = (src1 != zero_reg);
  assign src2_used = (src2 != zero_reg);

endmodule

// ==== verilog/map_table.sv ====
// map table: arch-to-phys tags, ready bits, rename and CDB wakeup
module map_table
  import rename_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rename_en,
  input  logic [arch_idx_w-1:0] dest,
  input  logic [arch_idx_w-1:0] src1,
  input  logic [arch_idx_w-1:0] src2,
  input  logic                  src1_used,
  input  logic                  src2_used,
  input  logic [phys_idx_w-1:0] new_tag,
  input  logic                  cdb_valid,
  input  logic [phys_idx_w-1:0] cdb_tag,
  output logic [phys_idx_w-1:0] t1,
  output logic                  t1_ready,
  output logic [phys_idx_w-1:0] t2,
  output logic                  t2_ready,
  output logic [phys_idx_w-1:0] t_old
);

  logic [phys_idx_w-1:0] tag_q [arch_regs];
  logic [arch_regs-1:0]  ready_q;
  logic                  cdb_hit1;
  logic                  cdb_hit2;

  ////////////////////////////////////////////////////////////
  // table update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int r = 0; r < arch_regs; r++) begin
        tag_q[r] <= phys_idx_w'(r);
      end
      ready_q <= '1;
    end else begin
      // wakeup, every entry holding the broadcast tag
      if (cdb_valid) begin
        for (int r = 0; r < arch_regs; r++) begin
          if (tag_q[r] == cdb_tag) begin
            ready_q[r] <= 1'b1;
          end
        end
      end
      // new mapping is not ready until its producer completes
      if (rename_en) begin
        tag_q[dest]   <= new_tag;
        ready_q[dest] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // source lookup
  ////////////////////////////////////////////////////////////

  // same-cycle bypass from the CDB
  assign cdb_hit1 = cdb_valid && (tag_q[src1] == cdb_tag);
  assign cdb_hit2 = cdb_valid && (tag_q[src2] == cdb_tag);

  // unused source reports its own index, ready
  assign t1       = src1_used ? tag_q[src1] : phys_idx_w'(src1);
  assign t1_ready = !src1_used || ready_q[src1] || cdb_hit1;
  assign t2       = src2_used ? tag_q[src2] : phys_idx_w'(src2);
  assign t2_ready = !src2_used || ready_q[src2] || cdb_hit2;

  // mapping being replaced, freed at retire
  assign t_old = tag_q[dest];

  // r31 keeps its identity mapping for good
  a_zero_never_renamed: assert property (
    @(posedge clock) disable iff (reset) rename_en |-> (dest != zero_reg)
  );

endmodule

// ==== verilog/rename_core.sv ====
// rename core top: decoder, map table, free list and reorder buffer
module rename_core
  import rename_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  inst_valid,
  input  inst_word_t            inst_word,
  input  logic                  complete_valid,
  input  logic [rob_idx_w-1:0]  complete_rob_idx,
  output logic                  dispatch_ready,
  output logic [rob_idx_w-1:0]  dispatch_rob_idx,
  output logic                  dispatch_writes,
  output logic [phys_idx_w-1:0] dispatch_t_new,
  output logic [phys_idx_w-1:0] dispatch_t_old,
  output logic [phys_idx_w-1:0] dispatch_t1,
  output logic                  dispatch_t1_ready,
  output logic [phys_idx_w-1:0] dispatch_t2,
  output logic                  dispatch_t2_ready,
  output logic                  retire_valid,
  output logic [arch_idx_w-1:0] retire_arch_reg,
  output logic [phys_idx_w-1:0] retire_t_new,
  output logic [phys_idx_w-1:0] retire_t_old
);

  // decoded fields
  logic [arch_idx_w-1:0] dest;
  logic [arch_idx_w-1:0] src1;
  logic [arch_idx_w-1:0] src2;
  logic                  src1_used;
  logic                  src2_used;

  // dispatch control
  logic                  rob_full;
  logic                  dispatch;
  logic                  rename_en;

  // CDB and retire wiring
  logic                  cdb_valid;
  logic [phys_idx_w-1:0] cdb_tag;
  logic                  retire_writes;
  logic                  free_push;

  // taken only while the ROB has room
  assign dispatch_ready = !rob_full;
  assign dispatch       = inst_valid && dispatch_ready;
  // non-writers keep their mapping and their free tag
  assign rename_en      = dispatch && dispatch_writes;
  assign free_push      = retire_valid && retire_writes;

  inst_decoder u_inst_decoder (
    .inst_word (inst_word),
    .dest      (dest),
    .src1      (src1),
    .src2      (src2),
    .src1_used (src1_used),
    .src2_used (src2_used),
    .writes    (dispatch_writes)
  );

  map_table u_map_table (
    .clock     (clock),
    .reset     (reset),
    .rename_en (rename_en),
    .dest      (dest),
    .src1      (src1),
    .src2      (src2),
    .src1_used (src1_used),
    .src2_used (src2_used),
    .new_tag   (dispatch_t_new),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .t1        (dispatch_t1),
    .t1_ready  (dispatch_t1_ready),
    .t2        (dispatch_t2),
    .t2_ready  (dispatch_t2_ready),
    .t_old     (dispatch_t_old)
  );

  // old mapping goes back once its overwriter retires
  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (rename_en),
    .push     (free_push),
    .push_tag (retire_t_old),
    .head_tag (dispatch_t_new)
  );

  reorder_buffer u_reorder_buffer (
    .clock            (clock),
    .reset            (reset),
    .alloc            (dispatch),
    .alloc_writes     (dispatch_writes),
    .alloc_arch       (dest),
    .alloc_t_new      (dispatch_t_new),
    .alloc_t_old      (dispatch_t_old),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .full             (rob_full),
    .alloc_idx        (dispatch_rob_idx),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .retire_valid     (retire_valid),
    .retire_writes    (retire_writes),
    .retire_arch_reg  (retire_arch_reg),
    .retire_t_new     (retire_t_new),
    .retire_t_old     (retire_t_old)
  );

endmodule

// ==== verilog/rename_pkg.sv ====
// sizes, index widths, opcodes and the two views of an instruction word
package rename_pkg;

  ////////////////////////////////////////////////////////////
  // machine sizes
  ////////////////////////////////////////////////////////////

  // architectural and physical register counts
  localparam int arch_regs = 32;
  localparam int phys_regs = 64;
  // tags not mapped at reset start out free
  localparam int free_regs = phys_regs - arch_regs;
  localparam int rob_depth = 8;

  // index widths
  localparam int arch_idx_w = 5;
  localparam int phys_idx_w = 6;
  localparam int rob_idx_w  = 3;
  // free-list pointer width, 32 slots
  localparam int fl_idx_w   = 5;

  // r31 reads as zero, never renamed
  localparam logic [arch_idx_w-1:0] zero_reg = 5'd31;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////

  localparam int opcode_w = 6;

  // integer operate groups
  localparam logic [opcode_w-1:0] op_inta = 6'h10;
  localparam logic [opcode_w-1:0] op_intl = 6'h11;
  localparam logic [opcode_w-1:0] op_ints = 6'h12;
  localparam logic [opcode_w-1:0] op_intm = 6'h13;
  // quadword load and store
  localparam logic [opcode_w-1:0] op_ldq  = 6'h29;
  localparam logic [opcode_w-1:0] op_stq  = 6'h2D;

  ////////////////////////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////////////////////////

  // operate format, rb replaced by a literal when lit is set
  typedef struct packed {
    logic [opcode_w-1:0]   opcode;
    logic [arch_idx_w-1:0] ra;
    logic [arch_idx_w-1:0] rb;
    logic [2:0]            unused;
    logic                  lit;
    logic [6:0]            func;
    logic [arch_idx_w-1:0] rc;
  } operate_fmt_t;

  // memory format, loads write ra
  typedef struct packed {
    logic [opcode_w-1:0]   opcode;
    logic [arch_idx_w-1:0] ra;
    logic [arch_idx_w-1:0] rb;
    logic [15:0]           disp;
  } memory_fmt_t;

  // one 32-bit word, opcode sits in the same bits in both views
  typedef union packed {
    operate_fmt_t operate;
    memory_fmt_t  memory;
  } inst_word_t;

endpackage

// ==== verilog/reorder_buffer.sv ====
// reorder buffer: in-order queue, completion marks, CDB and retirement
module reorder_buffer
  import rename_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc,
  input  logic                  alloc_writes,
  input  logic [arch_idx_w-1:0] alloc_arch,
  input  logic [phys_idx_w-1:0] alloc_t_new,
  input  logic [phys_idx_w-1:0] alloc_t_old,
  input  logic                  complete_valid,
  input  logic [rob_idx_w-1:0]  complete_rob_idx,
  output logic                  full,
  output logic [rob_idx_w-1:0]  alloc_idx,
  output logic                  cdb_valid,
  output logic [phys_idx_w-1:0] cdb_tag,
  output logic                  retire_valid,
  output logic                  retire_writes,
  output logic [arch_idx_w-1:0] retire_arch_reg,
  output logic [phys_idx_w-1:0] retire_t_new,
  output logic [phys_idx_w-1:0] retire_t_old
);

  // per-entry state
  logic [rob_depth-1:0]  valid_q;
  logic [rob_depth-1:0]  complete_q;
  logic [rob_depth-1:0]  writes_q;
  logic [arch_idx_w-1:0] arch_q  [rob_depth];
  logic [phys_idx_w-1:0] t_new_q [rob_depth];
  logic [phys_idx_w-1:0] t_old_q [rob_depth];

  // queue pointers
  logic [rob_idx_w-1:0]  head;
  logic [rob_idx_w-1:0]  tail;
  logic [rob_idx_w:0]    count;

  logic                  complete_hit;
  logic                  retire_now;

  assign full      = (count == rob_depth);
  assign alloc_idx = tail;

  ////////////////////////////////////////////////////////////
  // completion and CDB
  ////////////////////////////////////////////////////////////

  // stray completions are dropped
  assign complete_hit = complete_valid && valid_q[complete_rob_idx];
  // stores and r31 targets wake nobody
  assign cdb_valid    = complete_hit && writes_q[complete_rob_idx];
  assign cdb_tag      = t_new_q[complete_rob_idx];

  // oldest entry leaves once marked
  assign retire_now = valid_q[head] && complete_q[head];

  ////////////////////////////////////////////////////////////
  // queue state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q    <= '0;
      complete_q <= '0;
      head       <= '0;
      tail       <= '0;
      count      <= '0;
    end else begin
      if (complete_hit) begin
        complete_q[complete_rob_idx] <= 1'b1;
      end
      if (alloc) begin
        valid_q[tail]    <= 1'b1;
        complete_q[tail] <= 1'b0;
        tail             <= tail + 1'b1;
      end
      if (retire_now) begin
        valid_q[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      // old count drives full, so both may happen together
      if (alloc && !retire_now) begin
        count <= count + 1'b1;
      end else if (!alloc && retire_now) begin
        count <= count - 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (alloc) begin
      writes_q[tail] <= alloc_writes;
      arch_q[tail]   <= alloc_arch;
      t_new_q[tail]  <= alloc_t_new;
      t_old_q[tail]  <= alloc_t_old;
    end
  end

  ////////////////////////////////////////////////////////////
  // retire register
  ////////////////////////////////////////////////////////////

  // one-cycle strobe after the retire edge
  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire_now;
    end
  end

  always_ff @(posedge clock) begin
    if (retire_now) begin
      retire_writes   <= writes_q[head];
      retire_arch_reg <= arch_q[head];
      retire_t_new    <= t_new_q[head];
      retire_t_old    <= t_old_q[head];
    end
  end

  // execution only completes what was dispatched and not yet retired
  a_complete_occupied: assert property (
    @(posedge clock) disable iff (reset) complete_valid |-> valid_q[complete_rob_idx]
  );

endmodule
